// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/rv_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assert (
  input logic                      clk,
  input logic                      rst_n_i,
  input logic                      imem_req_i,
  input logic                      imem_valid_i,
  input logic [core_pkg::XLEN-1:0] imem_addr_i,
  input logic                      redirect_i,
  input core_pkg::retire_t         retire_i
);

  // no fetch while held in reset
  req_low_in_reset: assert property (@(posedge clk) !rst_n_i |-> !imem_req_i)
    else $error("instruction request high during reset");

  // a waiting request keeps its address, a redirect may still move it
  addr_held: assert property (@(posedge clk) disable iff (!rst_n_i)
      imem_req_i && !imem_valid_i && !redirect_i |=> $stable(imem_addr_i))
    else $error("fetch address moved while the request was waiting");

  no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
      retire_i.valid |-> !(retire_i.we && retire_i.rd == '0))
    else $error("retire record writes x0");

endmodule

bind rv_core rv_core_assert u_assert (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .imem_req_i   (imem_req_o),
  .imem_valid_i (imem_valid_i),
  .imem_addr_i  (imem_addr_o),
  .redirect_i   (redirect),  // internal redirect pulse
  .retire_i     (retire_o)
);

`default_nettype wire

// File: bench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  import core_pkg::*;

  localparam int MAX_RETIRES   = 64;  // bound on retires over all tests
  localparam int WATCHDOG_CYCS = MAX_RETIRES * 8 + 200;

  logic            clk = 1'b0;
  logic            rst_n_i;
  logic            imem_valid_i;
  logic [ILEN-1:0] imem_rdata_i;
  logic            imem_req_o;
  logic [XLEN-1:0] imem_addr_o;
  retire_t         retire_o;

  logic [31:0] prog [64];
  int          prog_len;
  logic [63:0] prog_bytes;
  retire_t     expected [MAX_RETIRES];
  retire_t     exp_r;
  int          exp_len;
  int          ret_idx;
  logic        checking = 1'b0;
  logic        rand_waits = 1'b0;
  int          seed = 711;
  int          wait_left = -1;
  logic [63:0] last_addr = '0;
  logic [63:0] offset;
  int          errors = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          cur_test = 0;

  rv_core u_dut (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .imem_valid_i (imem_valid_i),
    .imem_rdata_i (imem_rdata_i),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .retire_o     (retire_o)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                         input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] lui_word(input int imm, input int rd);
    return {imm[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] branch_word(input int off, input int rs2, input int rs1,
                                              input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  task automatic append_word(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
    prog_bytes = prog_bytes + 64'd4;
  endtask

  task automatic load_program(input int num);
    prog_len = 0;
    prog_bytes = '0;
    case (num)
      1: begin
        append_word(i_type(5, 0, 0, 1));
        append_word(i_type(-3, 1, 0, 2));
      end
      2, 3: begin  // each op reads the previous result and the one before it
        append_word(i_type(7, 0, 0, 1));
        append_word(i_type(-2, 1, 0, 2));
        append_word(r_type(0, 1, 2, 0, 3));
        append_word(r_type(32, 2, 3, 0, 4));
        append_word(r_type(0, 4, 3, 7, 5));    // previous result on rs2
        append_word(r_type(0, 4, 5, 6, 6));
        append_word(r_type(0, 6, 5, 4, 7));    // previous result on rs2
        append_word(r_type(0, 6, 7, 2, 8));
        append_word(i_type(-1, 7, 7, 9));
        append_word(i_type(256, 9, 6, 10));
        append_word(i_type(-1, 10, 4, 11));
        append_word(r_type(0, 10, 11, 2, 12));
      end
      4: begin
        append_word(i_type(3, 0, 0, 1));
        append_word(i_type(0, 0, 0, 2));
        append_word(i_type(1, 2, 0, 2));      // loop body
        append_word(i_type(-1, 1, 0, 1));
        append_word(branch_word(-8, 0, 1, 1)); // bne back to the body twice
        append_word(branch_word(8, 1, 2, 0));  // beq not taken
        append_word(branch_word(8, 0, 1, 0));  // beq forward taken
        append_word(i_type(99, 0, 0, 3));
        append_word(branch_word(8, 0, 2, 1));  // bne forward taken
        append_word(i_type(77, 0, 0, 3));
        append_word(r_type(0, 3, 2, 0, 4));
      end
      5: begin
        append_word(lui_word('h80000, 1));
        append_word(i_type(-2048, 1, 0, 2));
        append_word(i_type(-1, 2, 4, 3));
        append_word(i_type(5, 0, 0, 0));
        append_word(lui_word('h12345, 0));
        append_word(r_type(0, 3, 0, 0, 4));
        append_word(i_type(-1, 0, 6, 5));
      end
      default: begin
        append_word(i_type(11, 0, 0, 1));
        append_word(i_type(5, 1, 2, 1));       // slti
        append_word(r_type(0, 1, 1, 1, 1));    // sll
        append_word(r_type(1, 1, 1, 0, 1));    // mul
        append_word(32'h0040_3083);            // ld x1, 4(x0)
        append_word(branch_word(8, 0, 0, 4));  // blt
        append_word(r_type(0, 0, 1, 0, 2));
      end
    endcase
  endtask

  // ISA-level model giving one record per executed instruction
  task automatic build_expected();
    logic [63:0]        regs [32];
    logic [63:0]        pc;
    logic [63:0]        off;
    logic [31:0]        ins;
    logic [63:0]        a;
    logic [63:0]        b;
    logic [63:0]        res;
    logic signed [63:0] imm_i;
    logic signed [63:0] imm_u;
    logic signed [63:0] imm_b;
    logic               wr;
    logic               taken;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = RESET_PC;
    off = '0;
    exp_len = 0;
    while (off < prog_bytes && exp_len < MAX_RETIRES) begin
      ins   = prog[off[7:2]];
      a     = regs[ins[19:15]];
      b     = regs[ins[24:20]];
      imm_i = 64'($signed(ins[31:20]));
      imm_u = 64'($signed({ins[31:12], 12'h000}));
      imm_b = 64'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
      wr    = 1'b1;
      taken = 1'b0;
      res   = '0;
      case (ins[6:0])
        7'h33: case ({ins[31:25], ins[14:12]})
          10'h000: res = a + b;
          10'h100: res = a - b;
          10'h007: res = a & b;
          10'h006: res = a | b;
          10'h004: res = a ^ b;
          10'h002: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          default: wr = 1'b0;
        endcase
        7'h13: case (ins[14:12])
          3'd0:    res = a + imm_i;
          3'd7:    res = a & imm_i;
          3'd6:    res = a | imm_i;
          3'd4:    res = a ^ imm_i;
          default: wr = 1'b0;
        endcase
        7'h37: res = imm_u;
        7'h63: begin
          wr = 1'b0;
          if (ins[14:12] == 3'd0) taken = (a == b);
          else if (ins[14:12] == 3'd1) taken = (a != b);
        end
        default: wr = 1'b0;
      endcase
      if (ins[11:7] == 5'd0) wr = 1'b0;
      if (wr) regs[ins[11:7]] = res;
      expected[exp_len] = {1'b1, pc, ins, ins[11:7], wr, res};
      exp_len++;
      pc  = taken ? pc + imm_b : pc + 64'd4;
      off = pc - RESET_PC;
    end
  endtask

  // memory answers the held address after 0 to 3 idle cycles
  always @(posedge clk) begin
    #1;
    offset = imem_addr_o - RESET_PC;
    if (!imem_req_o) begin
      imem_valid_i = 1'b0;
      wait_left = -1;
    end else begin
      if (imem_valid_i || imem_addr_o != last_addr || wait_left < 0) begin
        wait_left = rand_waits ? ($random(seed) & 3) : 0;
      end
      last_addr = imem_addr_o;
      if (wait_left == 0 && offset < prog_bytes) begin  // past the end never answers
        imem_valid_i = 1'b1;
        imem_rdata_i = prog[offset[7:2]];
      end else begin
        imem_valid_i = 1'b0;
        if (wait_left > 0) wait_left--;
      end
    end
  end

  always @(posedge clk) begin
    if (checking && retire_o.valid) begin
      if (ret_idx >= exp_len) begin
        $display("unexpected extra retire at %0t, pc %h", $time, retire_o.pc);
        errors++;
      end else begin
        exp_r = expected[ret_idx];
        assert (retire_o.pc == exp_r.pc && retire_o.instr == exp_r.instr) else begin
          $display("Mismatch at %0t: retire %0d pc %h instr %h, expected pc %h instr %h",
                   $time, ret_idx, retire_o.pc, retire_o.instr, exp_r.pc, exp_r.instr);
          errors++;
        end
        assert (retire_o.we == exp_r.we) else begin
          $display("Mismatch at %0t: retire %0d we %b, expected %b",
                   $time, ret_idx, retire_o.we, exp_r.we);
          errors++;
        end
        assert (!exp_r.we || (retire_o.rd == exp_r.rd && retire_o.data == exp_r.data)) else begin
          $display("Mismatch at %0t: retire %0d x%0d = %h, expected x%0d = %h", $time,
                   ret_idx, retire_o.rd, retire_o.data, exp_r.rd, exp_r.data);
          errors++;
        end
      end
      ret_idx++;
    end
  end

  task automatic run_test(input int num, input string name, input logic waits);
    int errs_before;
    errs_before = errors;
    cur_test = num;
    checking = 1'b0;
    @(posedge clk);
    #1;
    rst_n_i = 1'b0;
    load_program(num);
    build_expected();
    rand_waits = waits;
    ret_idx = 0;
    repeat (2) begin
      @(posedge clk);
      #1;
      assert (!imem_req_o && !retire_o.valid) else begin
        $display("request or retire active during reset at %0t", $time);
        errors++;
      end
    end
    checking = 1'b1;
    rst_n_i = 1'b1;
    @(posedge clk);
    #1;
    assert (imem_req_o && imem_addr_o == RESET_PC) else begin
      $display("Mismatch at %0t: first request req %b addr %h, expected addr %h",
               $time, imem_req_o, imem_addr_o, RESET_PC);
      errors++;
    end
    wait (ret_idx >= exp_len);
    repeat (4) @(posedge clk);  // drain so that extra retires get caught
    #1;
    if (errors == errs_before) begin
      pass_count++;
      $display("test %0d %s: ok, %0d retires", num, name, exp_len);
    end else begin
      fail_count++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
    end
  endtask

  initial begin
    rst_n_i      = 1'b1;
    imem_valid_i = 1'b0;
    imem_rdata_i = '0;
    #1 rst_n_i   = 1'b0;  // real falling edge for the async reset
    run_test(1, "reset", 1'b0);
    run_test(2, "dependent alu chain", 1'b0);
    run_test(3, "random wait states", 1'b1);
    run_test(4, "branches", 1'b1);
    run_test(5, "lui, immediates and x0", 1'b1);
    run_test(6, "unsupported encodings", 1'b1);
    $display("summary: %0d tests ok, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCS * 10);
    $display("timeout in test %0d: %0d of %0d expected retires seen", cur_test, ret_idx,
             exp_len);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_core.f
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/rv_core.sv
bench/rv_core_assert.sv
bench/tb_rv_core.sv

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int XLEN      = 64;  // register and pc width
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [ILEN-1:0]      instr;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic [XLEN-1:0]      imm;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [REG_IDX_W-1:0] rd;
    alu_op_e              alu_op;
    logic                 use_imm;  // operand b from imm
    logic                 we;
    logic                 is_branch;
    logic                 br_ne;    // bne when set, beq otherwise
  } id_ex_t;

  // execute/writeback record, also the retire trace
  typedef struct packed {
    logic                 valid;
    logic [XLEN-1:0]      pc;
    logic [ILEN-1:0]      instr;
    logic [REG_IDX_W-1:0] rd;
    logic                 we;
    logic [XLEN-1:0]      data;
  } retire_t;

endpackage

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  core_pkg::if_id_t               if_id_i,
  input  logic [core_pkg::XLEN-1:0]      rs1_val_i,
  input  logic [core_pkg::XLEN-1:0]      rs2_val_i,
  input  logic                           flush_i,
  output logic [core_pkg::REG_IDX_W-1:0] rs1_idx_o,
  output logic [core_pkg::REG_IDX_W-1:0] rs2_idx_o,
  output core_pkg::id_ex_t               id_ex_o
);

  import core_pkg::*;

  opcode_e         opc;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  id_ex_t          id_ex_d;

  assign opc       = opcode_e'(if_id_i.instr[6:0]);
  assign funct3    = if_id_i.instr[14:12];
  assign funct7    = if_id_i.instr[31:25];
  assign rs1_idx_o = if_id_i.instr[19:15];
  assign rs2_idx_o = if_id_i.instr[24:20];

  // sign-extended immediates
  assign imm_i = {{52{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
  assign imm_u = {{32{if_id_i.instr[31]}}, if_id_i.instr[31:12], 12'b0};
  assign imm_b = {{51{if_id_i.instr[31]}}, if_id_i.instr[31], if_id_i.instr[7],
                  if_id_i.instr[30:25], if_id_i.instr[11:8], 1'b0};

  always_comb begin
    id_ex_d           = '0;
    id_ex_d.valid     = if_id_i.valid & ~flush_i;  // flush leaves a bubble
    id_ex_d.pc        = if_id_i.pc;
    id_ex_d.instr     = if_id_i.instr;
    id_ex_d.rs1_val   = rs1_val_i;
    id_ex_d.rs2_val   = rs2_val_i;
    id_ex_d.rs1_idx   = rs1_idx_o;
    id_ex_d.rs2_idx   = rs2_idx_o;
    id_ex_d.rd        = if_id_i.instr[11:7];
    id_ex_d.alu_op    = ALU_ADD;

    case (opc)
      OPC_OP: begin
        id_ex_d.we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: id_ex_d.alu_op = ALU_ADD;
          {7'h20, 3'b000}: id_ex_d.alu_op = ALU_SUB;
          {7'h00, 3'b111}: id_ex_d.alu_op = ALU_AND;
          {7'h00, 3'b110}: id_ex_d.alu_op = ALU_OR;
          {7'h00, 3'b100}: id_ex_d.alu_op = ALU_XOR;
          {7'h00, 3'b010}: id_ex_d.alu_op = ALU_SLT;
          default:         id_ex_d.we     = 1'b0;  // unsupported, retires as nop
        endcase
      end
      OPC_OP_IMM: begin
        id_ex_d.we      = 1'b1;
        id_ex_d.use_imm = 1'b1;
        id_ex_d.imm     = imm_i;
        case (funct3)
          3'b000:  id_ex_d.alu_op = ALU_ADD;
          3'b111:  id_ex_d.alu_op = ALU_AND;
          3'b110:  id_ex_d.alu_op = ALU_OR;
          3'b100:  id_ex_d.alu_op = ALU_XOR;
          default: id_ex_d.we     = 1'b0;
        endcase
      end
      OPC_LUI: begin
        id_ex_d.we      = 1'b1;
        id_ex_d.use_imm = 1'b1;
        id_ex_d.imm     = imm_u;
        id_ex_d.alu_op  = ALU_PASS_B;
      end
      OPC_BRANCH: begin
        id_ex_d.imm       = imm_b;
        id_ex_d.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);  // beq, bne only
        id_ex_d.br_ne     = funct3[0];
      end
      default: ;  // other encodings write nothing
    endcase

    if (id_ex_d.rd == '0) begin
      id_ex_d.we = 1'b0;
    end
  end

  // decode/execute register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o.valid     <= 1'b0;
      id_ex_o.we        <= 1'b0;
      id_ex_o.is_branch <= 1'b0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  core_pkg::id_ex_t          id_ex_i,
  output core_pkg::retire_t         ex_wb_o,
  output logic                      redirect_o,
  output logic [core_pkg::XLEN-1:0] redirect_pc_o
);

  import core_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] rs2_fwd;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic            cmp_eq;
  retire_t         ex_wb_d;

  // bypass from the instruction one slot ahead
  function automatic logic [XLEN-1:0] fwd_operand(input retire_t              wb,
                                                  input logic [REG_IDX_W-1:0] idx,
                                                  input logic [XLEN-1:0]      reg_val);
    if (wb.valid && wb.we && wb.rd == idx) begin
      return wb.data;
    end
    return reg_val;
  endfunction

  assign op_a    = fwd_operand(ex_wb_o, id_ex_i.rs1_idx, id_ex_i.rs1_val);
  assign rs2_fwd = fwd_operand(ex_wb_o, id_ex_i.rs2_idx, id_ex_i.rs2_val);
  assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_res = op_a + op_b;
      ALU_SUB:    alu_res = op_a - op_b;
      ALU_AND:    alu_res = op_a & op_b;
      ALU_OR:     alu_res = op_a | op_b;
      ALU_XOR:    alu_res = op_a ^ op_b;
      ALU_SLT:    alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // branch compare always on the two registers
  assign cmp_eq        = (op_a == rs2_fwd);
  assign redirect_o    = id_ex_i.valid & id_ex_i.is_branch & (id_ex_i.br_ne ^ cmp_eq);
  assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

  always_comb begin
    ex_wb_d.valid = id_ex_i.valid;
    ex_wb_d.pc    = id_ex_i.pc;
    ex_wb_d.instr = id_ex_i.instr;
    ex_wb_d.rd    = id_ex_i.rd;
    ex_wb_d.we    = id_ex_i.we;  // low for branches and nops
    ex_wb_d.data  = alu_res;
  end

  // execute/writeback register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_wb_o.valid <= 1'b0;
      ex_wb_o.we    <= 1'b0;
    end else begin
      ex_wb_o <= ex_wb_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      imem_valid_i,
  input  logic [core_pkg::ILEN-1:0] imem_rdata_i,
  input  logic                      redirect_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
  output logic                      imem_req_o,
  output logic [core_pkg::XLEN-1:0] imem_addr_o,
  output core_pkg::if_id_t          if_id_o
);

  import core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            req_q;
  logic            accept;
  if_id_t          if_id_d;

  assign imem_req_o  = req_q;
  assign imem_addr_o = pc_q;  // held until the word comes back
  assign accept      = req_q & imem_valid_i;

  // pc and request level
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
      pc_q  <= RESET_PC;
    end else begin
      req_q <= 1'b1;  // request stays up once out of reset
      if (redirect_i) begin
        pc_q <= redirect_pc_i;  // redirect beats a same-cycle accept
      end else if (accept) begin
        pc_q <= pc_q + XLEN'(4);
      end
    end
  end

  always_comb begin
    if_id_d.valid = accept & ~redirect_i;  // drop the word fetched behind a taken branch
    if_id_d.pc    = pc_q;
    if_id_d.instr = imem_rdata_i;
  end

  // fetch/decode register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_o.valid <= 1'b0;
    end else begin
      if_id_o <= if_id_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  logic [core_pkg::REG_IDX_W-1:0] rs1_idx_i,
  input  logic [core_pkg::REG_IDX_W-1:0] rs2_idx_i,
  input  core_pkg::retire_t              wr_i,
  output logic [core_pkg::XLEN-1:0]      rs1_val_o,
  output logic [core_pkg::XLEN-1:0]      rs2_val_o
);

  import core_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];
  logic            wr_en;

  // x0 is never written, so it keeps its reset value of zero
  assign wr_en = wr_i.valid & wr_i.we & (wr_i.rd != '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  // write-through covers the instruction two slots behind the writer
  assign rs1_val_o = (wr_en && wr_i.rd == rs1_idx_i) ? wr_i.data : regs_q[rs1_idx_i];
  assign rs2_val_o = (wr_en && wr_i.rd == rs2_idx_i) ? wr_i.data : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      imem_valid_i,
  input  logic [core_pkg::ILEN-1:0] imem_rdata_i,
  output logic                      imem_req_o,
  output logic [core_pkg::XLEN-1:0] imem_addr_o,
  output core_pkg::retire_t         retire_o
);

  import core_pkg::*;

  if_id_t               if_id;
  id_ex_t               id_ex;
  logic                 redirect;     // also flushes decode
  logic [XLEN-1:0]      redirect_pc;
  logic [REG_IDX_W-1:0] rs1_idx;
  logic [REG_IDX_W-1:0] rs2_idx;
  logic [XLEN-1:0]      rs1_val;
  logic [XLEN-1:0]      rs2_val;

  fetch_unit u_fetch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .imem_valid_i  (imem_valid_i),
    .imem_rdata_i  (imem_rdata_i),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .if_id_o       (if_id)
  );

  decode_stage u_decode (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .if_id_i   (if_id),
    .rs1_val_i (rs1_val),
    .rs2_val_i (rs2_val),
    .flush_i   (redirect),
    .rs1_idx_o (rs1_idx),
    .rs2_idx_o (rs2_idx),
    .id_ex_o   (id_ex)
  );

  // write port fed straight from the retire record
  reg_file u_regs (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .rs1_idx_i (rs1_idx),
    .rs2_idx_i (rs2_idx),
    .wr_i      (retire_o),
    .rs1_val_o (rs1_val),
    .rs2_val_o (rs2_val)
  );

  execute_stage u_exec (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .id_ex_i       (id_ex),
    .ex_wb_o       (retire_o),  // ex/wb register is the retire trace
    .redirect_o    (redirect),
    .redirect_pc_o (redirect_pc)
  );

endmodule

`default_nettype wire
